// ==== frog_config.svh ====
`ifndef FROG_CONFIG_SVH
`define FROG_CONFIG_SVH

// screen and playfield geometry in pixels.
`define FROG_SCREEN_W    640
`define FROG_SCREEN_H    480
`define FROG_BLOCK       32
`define FROG_SIZE        32
`define FROG_CAR_W       64

// the frog starts centred on the bottom row.
`define FROG_INIT_X      304
`define FROG_INIT_Y      448
`define FROG_END_AREA    15

`define FROG_DB_CYCLES   8   // stable cycles before a button level is accepted.
`define FROG_CAR_PERIOD  16  // cycles between two car steps.
`define FROG_POS_W       10

`endif

// ==== frog_pkg.sv ====
package frog_pkg;

    // top level game flow.
    typedef enum logic [1:0] {
        MENU    = 2'd0,
        PLAYING = 2'd1,
        DEAD    = 2'd2,
        WIN     = 2'd3
    } game_state_t;

    // bit positions on the four-way pad bus.
    typedef enum logic [1:0] {
        LEFT  = 2'd0,
        DOWN  = 2'd1,
        UP    = 2'd2,
        RIGHT = 2'd3
    } dir_t;

endpackage

// ==== debounce.sv ====
`timescale 1ns/1ps
`include "frog_config.svh"

module debounce (
    input  logic clk,
    input  logic rst_n,
    input  logic btn_in,
    output logic db_level,
    output logic db_tick
);
    localparam int cnt_w = $clog2(`FROG_DB_CYCLES + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`FROG_DB_CYCLES - 1);

    logic [cnt_w-1:0] cnt;
    logic             level_q;

    // the counter only runs while the raw input disagrees with the accepted level.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt      <= '0;
            db_level <= 1'b0;
        end else if (btn_in == db_level) begin
            cnt <= '0;  // a glitch that ends early starts the count over.
        end else if (cnt == cnt_last) begin
            cnt      <= '0;
            db_level <= btn_in;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // one cycle press pulse on the rising edge of the accepted level.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_q <= 1'b0;
            db_tick <= 1'b0;
        end else begin
            level_q <= db_level;
            db_tick <= db_level & ~level_q;
        end
    end

endmodule

// ==== frog.sv ====
`timescale 1ns/1ps
`include "frog_config.svh"

module frog (
    input  logic                    clk,
    input  logic                    rst_n,
    input  frog_pkg::game_state_t   state,
    input  logic [3:0]              pad,
    input  logic                    collision,
    output logic [`FROG_POS_W-1:0]  frog_x,
    output logic [`FROG_POS_W-1:0]  frog_y,
    output logic                    reached_end
);
    import frog_pkg::*;

    localparam logic [`FROG_POS_W-1:0] init_x   = `FROG_INIT_X;
    localparam logic [`FROG_POS_W-1:0] init_y   = `FROG_INIT_Y;
    localparam logic [`FROG_POS_W-1:0] block    = `FROG_BLOCK;
    localparam logic [`FROG_POS_W-1:0] frog_sz  = `FROG_SIZE;
    localparam logic [`FROG_POS_W-1:0] screen_w = `FROG_SCREEN_W;
    localparam logic [`FROG_POS_W-1:0] screen_h = `FROG_SCREEN_H;
    localparam logic [`FROG_POS_W-1:0] end_area = `FROG_END_AREA;

    logic [3:0] tick;  // indexed by dir_t.

    for (genvar i = 0; i < 4; i++) begin : g_pad_db
        debounce u_db (
            .clk      (clk),
            .rst_n    (rst_n),
            .btn_in   (pad[i]),
            .db_level (),
            .db_tick  (tick[i])
        );
    end

    // a hit or a return to the menu puts the frog back on the bottom row.
    always_ff @(posedge clk) begin
        if (!rst_n || collision || state == MENU) begin
            frog_x      <= init_x;
            frog_y      <= init_y;
            reached_end <= 1'b0;
        end else begin
            if (state == PLAYING) begin
                // one direction per tick, up has the highest priority.
                if (tick[UP]) begin
                    if (frog_y >= block) begin
                        frog_y <= frog_y - block;
                    end
                end else if (tick[DOWN]) begin
                    if (frog_y + frog_sz < screen_h) begin
                        frog_y <= frog_y + block;
                    end
                end else if (tick[LEFT]) begin
                    if (frog_x >= block) begin
                        frog_x <= frog_x - block;
                    end
                end else if (tick[RIGHT]) begin
                    if (frog_x + frog_sz < screen_w) begin
                        frog_x <= frog_x + block;
                    end
                end
            end
            reached_end <= (frog_y <= end_area);  // the top strip is the goal.
        end
    end

endmodule

// ==== car_lane.sv ====
`timescale 1ns/1ps
`include "frog_config.svh"

module car_lane #(
    parameter int lane_y    = 320,
    parameter int step      = 8,
    parameter int car_count = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  frog_pkg::game_state_t             state,
    output logic [car_count*`FROG_POS_W-1:0]  car_x
);
    import frog_pkg::*;

    localparam int screen_w = `FROG_SCREEN_W;
    localparam int spacing  = screen_w / car_count;
    localparam int per_w    = $clog2(`FROG_CAR_PERIOD);
    localparam logic [per_w-1:0] per_last = per_w'(`FROG_CAR_PERIOD - 1);

    logic [per_w-1:0]       per_cnt;
    logic [`FROG_POS_W-1:0] pos [car_count];

    // a lane must lie on the screen and a step must be shorter than the screen.
    if (lane_y < 0 || lane_y + `FROG_SIZE > `FROG_SCREEN_H) begin : g_bad_lane
        $error("car_lane: lane_y %0d lies outside the screen", lane_y);
    end
    if (step >= screen_w || -step >= screen_w) begin : g_bad_step
        $error("car_lane: step %0d is too large", step);
    end

    function automatic logic [`FROG_POS_W-1:0] advance(input logic [`FROG_POS_W-1:0] x);
        int sum;
        sum = int'(x) + step;
        if (sum >= screen_w) begin
            sum = sum - screen_w;
        end else if (sum < 0) begin
            sum = sum + screen_w;  // moving left wraps to the right edge.
        end
        return `FROG_POS_W'(sum);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n || state == MENU) begin
            per_cnt <= '0;
            for (int i = 0; i < car_count; i++) begin
                pos[i] <= `FROG_POS_W'(i * spacing);
            end
        end else if (state == PLAYING) begin
            if (per_cnt == per_last) begin
                per_cnt <= '0;
                for (int i = 0; i < car_count; i++) begin
                    pos[i] <= advance(pos[i]);
                end
            end else begin
                per_cnt <= per_cnt + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < car_count; i++) begin : g_out
        assign car_x[i*`FROG_POS_W +: `FROG_POS_W] = pos[i];
    end

endmodule

// ==== hit_detect.sv ====
`timescale 1ns/1ps
`include "frog_config.svh"

module hit_detect #(
    parameter int lane0_y = 320,
    parameter int lane1_y = 192
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`FROG_POS_W-1:0]    frog_x,
    input  logic [`FROG_POS_W-1:0]    frog_y,
    input  logic [2*`FROG_POS_W-1:0]  lane0_x,
    input  logic [2*`FROG_POS_W-1:0]  lane1_x,
    output logic                      collision
);
    localparam int cars = 2;
    localparam int w    = `FROG_POS_W;

    logic hit;

    // boxes overlap when they overlap on both axes.
    function automatic logic overlap(input int fx, input int fy, input int cx, input int cy);
        return (fx < cx + `FROG_CAR_W) && (cx < fx + `FROG_SIZE) &&
               (fy < cy + `FROG_SIZE) && (cy < fy + `FROG_SIZE);
    endfunction

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < cars; i++) begin
            hit = hit | overlap(int'(frog_x), int'(frog_y), int'(lane0_x[i*w +: w]), lane0_y);
            hit = hit | overlap(int'(frog_x), int'(frog_y), int'(lane1_x[i*w +: w]), lane1_y);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            collision <= 1'b0;
        end else begin
            collision <= hit;  // the frog is already back at the start one cycle later.
        end
    end

endmodule

// ==== game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_tick,
    input  logic                   collision,
    input  logic                   reached_end,
    output frog_pkg::game_state_t  state
);
    import frog_pkg::*;

    game_state_t state_next;

    always_comb begin
        state_next = state;
        unique case (state)
            MENU: begin
                if (start_tick) begin
                    state_next = PLAYING;
                end
            end
            PLAYING: begin
                // a hit counts even when the frog lands on the top strip.
                if (collision) begin
                    state_next = DEAD;
                end else if (reached_end) begin
                    state_next = WIN;
                end
            end
            DEAD: begin
                if (start_tick) begin
                    state_next = PLAYING;  // retry without going through the menu.
                end
            end
            WIN: begin
                if (start_tick) begin
                    state_next = MENU;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= MENU;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== frogger_top.sv ====
`timescale 1ns/1ps
`include "frog_config.svh"

module frogger_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic [3:0]                pad,
    output frog_pkg::game_state_t     state,
    output logic [`FROG_POS_W-1:0]    frog_x,
    output logic [`FROG_POS_W-1:0]    frog_y,
    output logic [2*`FROG_POS_W-1:0]  lane0_x,
    output logic [2*`FROG_POS_W-1:0]  lane1_x
);
    // lane 0 drifts right slowly, lane 1 runs left at twice the speed.
    localparam int lane0_y    = 320;
    localparam int lane0_step = 8;
    localparam int lane1_y    = 192;
    localparam int lane1_step = -16;

    logic start_tick;
    logic collision;
    logic reached_end;

    debounce u_start_db (
        .clk      (clk),
        .rst_n    (rst_n),
        .btn_in   (start),
        .db_level (),
        .db_tick  (start_tick)
    );

    frog u_frog (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .pad         (pad),
        .collision   (collision),
        .frog_x      (frog_x),
        .frog_y      (frog_y),
        .reached_end (reached_end)
    );

    car_lane #(.lane_y(lane0_y), .step(lane0_step), .car_count(2)) u_lane0 (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state),
        .car_x (lane0_x)
    );

    car_lane #(.lane_y(lane1_y), .step(lane1_step), .car_count(2)) u_lane1 (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state),
        .car_x (lane1_x)
    );

    hit_detect #(.lane0_y(lane0_y), .lane1_y(lane1_y)) u_hit_detect (
        .clk       (clk),
        .rst_n     (rst_n),
        .frog_x    (frog_x),
        .frog_y    (frog_y),
        .lane0_x   (lane0_x),
        .lane1_x   (lane1_x),
        .collision (collision)
    );

    game_fsm u_game_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_tick  (start_tick),
        .collision   (collision),
        .reached_end (reached_end),
        .state       (state)
    );

endmodule

// ==== frogger_properties.sv ====
`timescale 1ns/1ps
`include "frog_config.svh"

module frogger_properties (
    input logic                    clk,
    input logic                    rst_n,
    input frog_pkg::game_state_t   state,
    input logic [`FROG_POS_W-1:0]  frog_x,
    input logic [`FROG_POS_W-1:0]  frog_y,
    input logic                    collision
);
    import frog_pkg::*;

    // the menu only ever leads into a round.
    menu_exit: assert property (@(posedge clk) disable iff (!rst_n)
        state == MENU |=> state inside {MENU, PLAYING})
        else $error("state left the menu for a state other than playing");

    // the frog box never crosses the right or bottom edge.
    frog_on_screen: assert property (@(posedge clk) disable iff (!rst_n)
        (int'(frog_x) + `FROG_SIZE <= `FROG_SCREEN_W) &&
        (int'(frog_y) + `FROG_SIZE <= `FROG_SCREEN_H))
        else $error("frog left the screen at x %0d y %0d", frog_x, frog_y);

    frog_on_grid: assert property (@(posedge clk) disable iff (!rst_n)
        (int'(frog_x) % `FROG_BLOCK == `FROG_INIT_X % `FROG_BLOCK) &&
        (int'(frog_y) % `FROG_BLOCK == `FROG_INIT_Y % `FROG_BLOCK))
        else $error("frog is off the block grid at x %0d y %0d", frog_x, frog_y);

    restart_after_hit: assert property (@(posedge clk) disable iff (!rst_n)
        collision |=> (int'(frog_x) == `FROG_INIT_X) && (int'(frog_y) == `FROG_INIT_Y))
        else $error("frog did not return to the start after a hit");

endmodule

bind frogger_top frogger_properties u_frogger_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .frog_x    (frog_x),
    .frog_y    (frog_y),
    .collision (collision)
);

// ==== tb_frogger.sv ====
`timescale 1ns/1ps
`include "frog_config.svh"

module tb_frogger;
    import frog_pkg::*;

    localparam int btn_start   = 4;
    localparam int hold_cycles = `FROG_DB_CYCLES + 4;
    localparam int row_timeout = 64;
    localparam int wrap_cycles = (`FROG_SCREEN_W / 8) * `FROG_CAR_PERIOD;  // slowest lane.
    localparam int lane0_y     = 320;
    localparam int lane0_step  = 8;
    localparam int lane1_y     = 192;
    localparam int lane1_step  = -16;
    localparam logic [9:0] start_x = `FROG_INIT_X;
    localparam logic [9:0] start_y = `FROG_INIT_Y;
    localparam logic [19:0] lane_home = {10'(`FROG_SCREEN_W / 2), 10'd0};  // two cars, even gaps.

    typedef struct packed {
        logic [2:0]  btn;
        game_state_t st;
        logic [9:0]  x;
        logic [9:0]  y;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [3:0]  pad;
    game_state_t state;
    logic [9:0]  frog_x;
    logic [9:0]  frog_y;
    logic [19:0] lane0_x;
    logic [19:0] lane1_x;

    row_t        rows[$];
    logic [19:0] lane0_hist [0:1];
    logic [19:0] lane1_last;
    logic [9:0]  fx_hist [0:1];
    logic [9:0]  fy_hist [0:1];
    game_state_t state_prev;
    logic        death_seen;
    logic [19:0] death_lane0;
    logic [9:0]  death_fx;
    logic [9:0]  death_fy;

    frogger_top u_frogger_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .pad     (pad),
        .state   (state),
        .frog_x  (frog_x),
        .frog_y  (frog_y),
        .lane0_x (lane0_x),
        .lane1_x (lane1_x)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // every car of a lane advances by the lane step and wraps at the screen edge.
    function automatic logic lane_stepped(input logic [19:0] prev, input logic [19:0] now,
                                          input int step);
        for (int c = 0; c < 2; c++) begin
            if (int'(now[c*10 +: 10])
                != (int'(prev[c*10 +: 10]) + step + `FROG_SCREEN_W) % `FROG_SCREEN_W) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // keeps the last two samples so the hit that caused a death can be looked up.
    always @(negedge clk) begin
        if (!rst_n) begin
            death_seen <= 1'b0;
            state_prev <= MENU;
        end else begin
            lane0_hist[1] <= lane0_hist[0];
            lane0_hist[0] <= lane0_x;
            lane1_last    <= lane1_x;
            fx_hist[1]    <= fx_hist[0];
            fx_hist[0]    <= frog_x;
            fy_hist[1]    <= fy_hist[0];
            fy_hist[0]    <= frog_y;
            state_prev    <= state;
            // cars only ever move by one step while a round is running.
            if (state_prev == PLAYING && (lane0_x != lane0_hist[0] || lane1_x != lane1_last)) begin
                assert (lane_stepped(lane0_hist[0], lane0_x, lane0_step)
                        && lane_stepped(lane1_last, lane1_x, lane1_step)) else
                    report_failure($sformatf(
                        "Error: at %0t ns cars jumped, lane0 %h to %h, lane1 %h to %h",
                        $time, lane0_hist[0], lane0_x, lane1_last, lane1_x));
            end
            if (state == DEAD && state_prev != DEAD) begin
                death_seen  <= 1'b1;
                death_lane0 <= lane0_hist[1];  // the overlap was two samples before DEAD.
                death_fx    <= fx_hist[1];
                death_fy    <= fy_hist[1];
            end
        end
    end

    task automatic add_row(input int btn, input game_state_t st, input int x, input int y);
        row_t r;
        r.btn = 3'(btn);
        r.st  = st;
        r.x   = 10'(x);
        r.y   = 10'(y);
        rows.push_back(r);
    endtask

    // holds a button long enough for the debouncer, then lets it settle released.
    task automatic press(input int btn);
        @(posedge clk);
        #1;
        if (btn == btn_start) begin
            start = 1'b1;
        end else begin
            pad[btn] = 1'b1;
        end
        repeat (hold_cycles) @(posedge clk);
        #1;
        start = 1'b0;
        pad   = '0;
        repeat (hold_cycles) @(posedge clk);
    endtask

    task automatic expect_outputs(input game_state_t st, input logic [9:0] x,
                                  input logic [9:0] y, input int timeout);
        int n;
        n = 0;
        @(negedge clk);
        while (!(state == st && frog_x == x && frog_y == y) && n < timeout) begin
            @(negedge clk);
            n++;
        end
        assert (state == st && frog_x == x && frog_y == y) else
            report_failure($sformatf("Error: at %0t ns expected %s x %0d y %0d, got %s x %0d y %0d",
                $time, st.name(), x, y, state.name(), frog_x, frog_y));
    endtask

    task automatic expect_lanes_home(input int timeout);
        int n;
        n = 0;
        @(negedge clk);
        while (!(lane0_x == lane_home && lane1_x == lane_home) && n < timeout) begin
            @(negedge clk);
            n++;
        end
        assert (lane0_x == lane_home && lane1_x == lane_home) else
            report_failure($sformatf("Error: at %0t ns expected cars at %h, got lane0 %h lane1 %h",
                $time, lane_home, lane0_x, lane1_x));
    endtask

    function automatic logic box_hit(input int fx, input int fy, input int cx, input int cy);
        if (cx + `FROG_CAR_W <= fx || fx + `FROG_SIZE <= cx) begin
            return 1'b0;
        end
        if (cy + `FROG_SIZE <= fy || fy + `FROG_SIZE <= cy) begin
            return 1'b0;  // separated vertically.
        end
        return 1'b1;
    endfunction

    // a lane is clear when no car touches the frog over the next few steps.
    function automatic logic lane_clear(input logic [19:0] cars, input int ly, input int step,
                                        input int fx, input int fy);
        int cx;
        if (fy != ly) begin
            return 1'b1;
        end
        for (int c = 0; c < 2; c++) begin
            for (int k = 0; k <= 4; k++) begin
                cx = (int'(cars[c*10 +: 10]) + k * step + `FROG_SCREEN_W) % `FROG_SCREEN_W;
                if (box_hit(fx, fy, cx, ly)) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    function automatic logic row_safe(input int y);
        return lane_clear(lane0_x, lane0_y, lane0_step, `FROG_INIT_X, y)
            && lane_clear(lane1_x, lane1_y, lane1_step, `FROG_INIT_X, y);
    endfunction

    task automatic hop_up(input logic [9:0] target_y, input game_state_t st);
        int n;
        n = 0;
        @(negedge clk);
        while (!row_safe(int'(target_y)) && n < 4 * wrap_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (row_safe(int'(target_y))) else
            report_failure("no gap in the cars appeared before the timeout");
        press(UP);
        expect_outputs(st, start_x, target_y, row_timeout);
    endtask

    initial begin
        int   ex;
        int   n;
        logic hit_car;
        clk   = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        pad   = '0;

        add_row(UP, MENU, 304, 448);  // the menu keeps the frog parked.
        add_row(btn_start, PLAYING, 304, 448);
        add_row(RIGHT, PLAYING, 336, 448);
        add_row(LEFT, PLAYING, 304, 448);
        add_row(UP, PLAYING, 304, 416);
        add_row(DOWN, PLAYING, 304, 448);
        add_row(DOWN, PLAYING, 304, 448);  // bottom edge refuses the move.
        ex = 304;
        for (int i = 0; i < 15; i++) begin
            if (ex >= `FROG_BLOCK) begin
                ex = ex - `FROG_BLOCK;
            end
            add_row(LEFT, PLAYING, ex, 448);
        end
        for (int y = 416; y >= 352; y -= 32) begin
            add_row(UP, PLAYING, ex, y);
        end

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        expect_outputs(MENU, start_x, start_y, row_timeout);
        expect_lanes_home(row_timeout);

        foreach (rows[i]) begin
            press(int'(rows[i].btn));
            expect_outputs(rows[i].st, rows[i].x, rows[i].y, row_timeout);
        end

        // step into the lower lane and stay until a car arrives.
        press(UP);
        n = 0;
        while (!death_seen && n < 4 * wrap_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (death_seen) else
            report_failure("no car hit the frog in its lane row before the timeout");
        hit_car = box_hit(int'(death_fx), int'(death_fy), int'(death_lane0[9:0]), lane0_y)
               || box_hit(int'(death_fx), int'(death_fy), int'(death_lane0[19:10]), lane0_y);
        assert (hit_car && death_fy == 10'(lane0_y)) else
            report_failure($sformatf("Error: at %0t ns frog at x %0d y %0d was not inside a car",
                $time, death_fx, death_fy));
        expect_outputs(DEAD, start_x, start_y, row_timeout);
        press(btn_start);
        expect_outputs(PLAYING, start_x, start_y, row_timeout);

        for (int y = 416; y >= 0; y -= 32) begin
            hop_up(10'(y), (y == 0) ? WIN : PLAYING);
        end
        press(btn_start);
        expect_outputs(MENU, start_x, start_y, row_timeout);
        expect_lanes_home(row_timeout);

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
frog_pkg.sv
debounce.sv
frog.sv
car_lane.sv
hit_detect.sv
game_fsm.sv
frogger_top.sv
frogger_properties.sv
tb_frogger.sv

// ==== run.sh ====
#!/bin/sh
# builds the frogger testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_frogger -f tb.f -o sim_frogger
./obj_dir/sim_frogger 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished cleanly"
